//--- source/fetch_pkg.sv
// types and encodings shared by the fetch front end
// a line is little endian, parcel 0 sits at the lowest address
`default_nettype none

package fetch_pkg;

  // ##########################################################
  // instruction storage
  // ##########################################################

  typedef logic [15:0] parcel_t;

  // one 64-bit fetch line, seen as parcels or as aligned words
  typedef union packed {
    parcel_t [3:0]    parcels;
    logic [1:0][31:0] words;
  } line_u;

  localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0

  // ##########################################################
  // opcodes used by the predecode
  // ##########################################################

  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_branch = 7'b110_0011;

  // quadrant 1 funct3 values of the compressed control transfers
  localparam logic [2:0] c_funct_j    = 3'b101;
  localparam logic [2:0] c_funct_beqz = 3'b110;
  localparam logic [2:0] c_funct_bnez = 3'b111;

endpackage

`default_nettype wire

//--- source/fetch_mem_ctrl.sv
// single-beat 64-bit AXI reads, at most two lines buffered or in flight
// responses come back in order; the read ID carries the fetch epoch
`timescale 1ns/1ns
`default_nettype none

module fetch_mem_ctrl #(
  parameter int unsigned axi_id_width = 2,
  parameter logic [31:0] reset_pc     = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    redirect,
  input  logic [31:1]             redirect_pc,
  input  logic                    line_pop,
  output logic                    axi_arvalid,
  input  logic                    axi_arready,
  output logic [31:0]             axi_araddr,
  output logic [axi_id_width-1:0] axi_arid,
  input  logic                    axi_rvalid,
  input  logic [63:0]             axi_rdata,
  input  logic [axi_id_width-1:0] axi_rid,
  input  logic [1:0]              axi_rresp,
  output logic                    axi_rready,
  output logic                    line_valid,
  output fetch_pkg::line_u        line_data,
  output logic [31:1]             line_pc,
  output logic                    line_fault
);

  import fetch_pkg::*;

  logic [31:3]             fetch_ptr;   // next line to request
  logic [31:3]             head_addr;   // address of the buffer head line
  logic [1:0]              entry_off;   // parcel offset for the next accepted line
  logic [axi_id_width-1:0] epoch;
  logic [1:0]              inflight;    // includes reads of older epochs
  logic [1:0]              fifo_cnt;
  logic                    rd_ptr;
  logic                    wr_ptr;
  line_u                   buf_data [2];
  logic [1:0]              buf_off [2];
  logic                    buf_fault [2];
  logic                    issue;
  logic                    push;

  assign axi_rready = 1'b1;  // a slot is reserved when the read is issued

  assign push  = axi_rvalid && (axi_rid == epoch) && !redirect;
  assign issue = !redirect && (!axi_arvalid || axi_arready) &&
                 (({1'b0, fifo_cnt} + {1'b0, inflight}) < 3'd2);

  // ##########################################################
  // read address channel
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      axi_arvalid <= 1'b0;
      axi_araddr  <= '0;
      axi_arid    <= '0;
      fetch_ptr   <= reset_pc[31:3];
    end else begin
      if (issue) begin
        axi_arvalid <= 1'b1;
        axi_araddr  <= {fetch_ptr, 3'b000};
        axi_arid    <= epoch;
        fetch_ptr   <= fetch_ptr + 1'b1;
      end else if (axi_arready) begin
        axi_arvalid <= 1'b0;
      end
      if (redirect) fetch_ptr <= redirect_pc[31:3];
    end
  end

  // ##########################################################
  // epoch, counters and line buffer control
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      epoch     <= '0;
      inflight  <= '0;
      fifo_cnt  <= '0;
      rd_ptr    <= 1'b0;
      wr_ptr    <= 1'b0;
      head_addr <= reset_pc[31:3];
      entry_off <= reset_pc[2:1];
    end else begin
      inflight <= inflight + {1'b0, issue} - {1'b0, axi_rvalid};
      if (redirect) begin
        epoch     <= epoch + 1'b1;  // reads still in flight become stale
        fifo_cnt  <= '0;
        rd_ptr    <= 1'b0;
        wr_ptr    <= 1'b0;
        head_addr <= redirect_pc[31:3];
        entry_off <= redirect_pc[2:1];
      end else begin
        fifo_cnt <= fifo_cnt + {1'b0, push} - {1'b0, line_pop};
        if (push) begin
          wr_ptr    <= ~wr_ptr;
          entry_off <= 2'd0;  // only the first line after a redirect is entered mid-line
        end
        if (line_pop) begin
          rd_ptr    <= ~rd_ptr;
          head_addr <= head_addr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_data[wr_ptr]  <= axi_rdata;
      buf_off[wr_ptr]   <= entry_off;
      buf_fault[wr_ptr] <= (axi_rresp != 2'b00);
    end
  end

  assign line_valid = (fifo_cnt != 2'd0);
  assign line_data  = buf_data[rd_ptr];
  assign line_pc    = {head_addr, buf_off[rd_ptr]};
  assign line_fault = buf_fault[rd_ptr];

endmodule

`default_nettype wire

//--- source/parcel_predecode.sv
// decodes one parcel position as if an instruction starts there
// odd positions never start a 32-bit instruction
`timescale 1ns/1ns
`default_nettype none

module parcel_predecode #(
  parameter int unsigned parcel_idx = 0
) (
  input  fetch_pkg::parcel_t parcel,
  input  fetch_pkg::parcel_t next_parcel,
  output logic               comp,
  output logic               illegal,
  output logic               is_br,
  output logic               pred_taken,
  output logic [20:0]        br_off
);

  import fetch_pkg::*;

  localparam bit can_start_32 = (parcel_idx % 2 == 0);

  logic [31:0] word;
  logic [20:0] j_off;
  logic [20:0] b_off;
  logic [20:0] cj_off;
  logic [20:0] cb_off;
  logic        quad1;

  assign word  = {next_parcel, parcel};
  assign comp  = (parcel[1:0] != 2'b11);
  assign quad1 = (parcel[1:0] == 2'b01);

  assign illegal = (parcel == '0) || (word == '1);

  // immediates, sign extended to the 21-bit byte offset of jal
  assign j_off  = {word[31], word[19:12], word[20], word[30:21], 1'b0};
  assign b_off  = {{8{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign cj_off = {{9{parcel[12]}}, parcel[12], parcel[8], parcel[10:9], parcel[6],
                   parcel[7], parcel[2], parcel[11], parcel[5:3], 1'b0};
  assign cb_off = {{12{parcel[12]}}, parcel[12], parcel[6:5], parcel[2],
                   parcel[11:10], parcel[4:3], 1'b0};

  always_comb begin
    is_br      = 1'b0;
    pred_taken = 1'b0;
    br_off     = '0;
    if (comp) begin
      if (quad1 && parcel[15:13] == c_funct_j) begin
        is_br      = 1'b1;
        pred_taken = 1'b1;
        br_off     = cj_off;
      end else if (quad1 && (parcel[15:13] == c_funct_beqz ||
                             parcel[15:13] == c_funct_bnez)) begin
        is_br      = 1'b1;
        pred_taken = cb_off[20];  // backward branches predicted taken
        br_off     = cb_off;
      end
    end else if (can_start_32) begin
      if (word[6:0] == op_jal) begin
        is_br      = 1'b1;
        pred_taken = 1'b1;
        br_off     = j_off;
      end else if (word[6:0] == op_branch) begin
        is_br      = 1'b1;
        pred_taken = b_off[20];
        br_off     = b_off;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_sequencer.sv
// issues one instruction per cycle from the head line, no stall from decode
// a 32-bit instruction is assumed to sit in parcels 0-1 or 2-3
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    br_misp_m,
  input  logic [31:1]             pc_m,
  input  logic                    line_valid,
  input  fetch_pkg::line_u        line_data,
  input  logic [31:1]             line_pc,
  input  logic                    line_fault,
  input  logic [3:0]              comp,
  input  logic [3:0]              illegal,
  input  logic [3:0]              is_br,
  input  logic [3:0]              pred_taken,
  input  logic [3:0][20:0]        br_off,
  output logic                    line_pop,
  output logic                    redirect,
  output logic [31:1]             redirect_pc,
  output logic                    valid_d0,
  output logic [31:0]             instr_d0,
  output logic [31:1]             pc_d0,
  output logic                    comp_d0,
  output logic                    br_d0,
  output logic                    br_ataken_d0,
  output logic                    illegal_d0
);

  import fetch_pkg::*;

  // the wait state means the start of a line, entered at line_pc[2:1]
  localparam logic [2:0] sel_wait = 3'b100;

  logic [2:0]  sel;
  logic [1:0]  cur;
  logic [1:0]  nxt;
  logic        leave;
  logic        emit;
  logic        taken;
  logic [31:1] cur_pc;
  logic [31:1] taken_pc;
  logic [31:0] instr_sel;

  assign cur    = (sel == sel_wait) ? line_pc[2:1] : sel[1:0];
  assign cur_pc = {line_pc[31:3], cur};
  assign emit   = line_valid && !br_misp_m;  // a mispredict drops this cycle's pick
  assign taken  = emit && is_br[cur] && pred_taken[cur];

  assign taken_pc = cur_pc + {{11{br_off[cur][20]}}, br_off[cur][20:1]};

  always_comb begin
    nxt   = 2'd0;
    leave = 1'b0;
    case (cur)
      2'd0: nxt = comp[0] ? 2'd1 : 2'd2;
      2'd1: nxt = 2'd2;
      2'd2: begin
        nxt   = 2'd3;
        leave = !comp[2];
      end
      default: leave = 1'b1;
    endcase
  end

  // odd parcels only hold compressed code, zero-extend them either way
  assign instr_sel = (comp[cur] || cur[0]) ? {16'h0000, line_data.parcels[cur]}
                                           : line_data.words[cur[1]];

  assign line_pop    = emit && leave;
  assign redirect    = br_misp_m || taken;
  assign redirect_pc = br_misp_m ? pc_m : taken_pc;

  // ##########################################################
  // parcel select state
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel <= sel_wait;
    end else if (redirect) begin
      sel <= sel_wait;
    end else if (emit) begin
      sel <= leave ? sel_wait : {1'b0, nxt};
    end
  end

  // ##########################################################
  // decode stage registers
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d0     <= 1'b0;
      instr_d0     <= nop_instr;
      pc_d0        <= '0;
      comp_d0      <= 1'b0;
      br_d0        <= 1'b0;
      br_ataken_d0 <= 1'b0;
      illegal_d0   <= 1'b0;
    end else begin
      valid_d0 <= emit;
      if (emit) begin
        instr_d0     <= instr_sel;
        pc_d0        <= cur_pc;
        comp_d0      <= comp[cur];
        br_d0        <= is_br[cur];
        br_ataken_d0 <= taken;
        illegal_d0   <= illegal[cur] || line_fault;  // bus error marks the whole line
      end else begin
        instr_d0     <= nop_instr;
        comp_d0      <= 1'b0;
        br_d0        <= 1'b0;
        br_ataken_d0 <= 1'b0;
        illegal_d0   <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
// fetch front end top; the AXI port is read only with single-beat reads
// axi_id_width must be at least 1
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter int unsigned axi_id_width = 2,
  parameter logic [31:0] reset_pc     = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    axi_arvalid,
  input  logic                    axi_arready,
  output logic [31:0]             axi_araddr,
  output logic [axi_id_width-1:0] axi_arid,
  input  logic                    axi_rvalid,
  input  logic [63:0]             axi_rdata,
  input  logic [axi_id_width-1:0] axi_rid,
  input  logic [1:0]              axi_rresp,
  output logic                    axi_rready,
  input  logic                    br_misp_m,
  input  logic [31:1]             pc_m,
  output logic                    valid_d0,
  output logic [31:0]             instr_d0,
  output logic [31:1]             pc_d0,
  output logic                    comp_d0,
  output logic                    br_d0,
  output logic                    br_ataken_d0,
  output logic                    illegal_d0
);

  import fetch_pkg::*;

  logic             redirect;
  logic [31:1]      redirect_pc;
  logic             line_pop;
  logic             line_valid;
  line_u            line_data;
  logic [31:1]      line_pc;
  logic             line_fault;
  parcel_t [4:0]    parcel_ext;  // last slot is zero, seen by the top parcel
  logic [3:0]       comp;
  logic [3:0]       illegal;
  logic [3:0]       is_br;
  logic [3:0]       pred_taken;
  logic [3:0][20:0] br_off;

  assign parcel_ext = {16'h0000, line_data.parcels};

  fetch_mem_ctrl #(
    .axi_id_width(axi_id_width),
    .reset_pc    (reset_pc)
  ) i_mem_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .line_pop   (line_pop),
    .axi_arvalid(axi_arvalid),
    .axi_arready(axi_arready),
    .axi_araddr (axi_araddr),
    .axi_arid   (axi_arid),
    .axi_rvalid (axi_rvalid),
    .axi_rdata  (axi_rdata),
    .axi_rid    (axi_rid),
    .axi_rresp  (axi_rresp),
    .axi_rready (axi_rready),
    .line_valid (line_valid),
    .line_data  (line_data),
    .line_pc    (line_pc),
    .line_fault (line_fault)
  );

  for (genvar i = 0; i < 4; i++) begin : g_predecode
    parcel_predecode #(
      .parcel_idx(i)
    ) i_predecode (
      .parcel     (parcel_ext[i]),
      .next_parcel(parcel_ext[i+1]),
      .comp       (comp[i]),
      .illegal    (illegal[i]),
      .is_br      (is_br[i]),
      .pred_taken (pred_taken[i]),
      .br_off     (br_off[i])
    );
  end

  fetch_sequencer i_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .br_misp_m   (br_misp_m),
    .pc_m        (pc_m),
    .line_valid  (line_valid),
    .line_data   (line_data),
    .line_pc     (line_pc),
    .line_fault  (line_fault),
    .comp        (comp),
    .illegal     (illegal),
    .is_br       (is_br),
    .pred_taken  (pred_taken),
    .br_off      (br_off),
    .line_pop    (line_pop),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .valid_d0    (valid_d0),
    .instr_d0    (instr_d0),
    .pc_d0       (pc_d0),
    .comp_d0     (comp_d0),
    .br_d0       (br_d0),
    .br_ataken_d0(br_ataken_d0),
    .illegal_d0  (illegal_d0)
  );

endmodule

`default_nettype wire

//--- verif/fetch_assertions.sv
// protocol and output timing properties, bound into fetch_top
`timescale 1ns/1ns
`default_nettype none

module fetch_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        axi_arvalid,
  input logic        axi_arready,
  input logic [31:0] axi_araddr,
  input logic        axi_rvalid,
  input logic        br_misp_m,
  input logic        valid_d0
);

  logic [2:0] outstanding;  // accepted reads not yet answered, rready is always high

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + {2'b00, axi_arvalid && axi_arready} - {2'b00, axi_rvalid};
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
    else $error("read request dropped or changed before arready");

  max_reads: assert property (@(posedge clk) disable iff (!rst_n) outstanding <= 3'd2)
    else $error("more than two reads outstanding");

  misp_bubble: assert property (@(posedge clk) disable iff (!rst_n) br_misp_m |=> !valid_d0)
    else $error("valid_d0 high in the cycle after a mispredict");

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_d0)
    else $error("valid_d0 high during reset");

endmodule

bind fetch_top fetch_assertions i_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .axi_arvalid(axi_arvalid),
  .axi_arready(axi_arready),
  .axi_araddr (axi_araddr),
  .axi_rvalid (axi_rvalid),
  .br_misp_m  (br_misp_m),
  .valid_d0   (valid_d0)
);

`default_nettype wire

//--- verif/fetch_tb.sv
// random program testbench for fetch_top with an in-order AXI memory model
// program is 4 KiB at address 0 and addresses above it alias onto it
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;

  localparam int n_per_test  = 1500;
  localparam int n_tests     = 4;
  localparam int cycle_limit = 40 * n_per_test * n_tests;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        axi_arvalid;
  logic        axi_arready = 1'b0;
  logic [31:0] axi_araddr;
  logic [1:0]  axi_arid;
  logic        axi_rvalid = 1'b0;
  logic [63:0] axi_rdata = '0;
  logic [1:0]  axi_rid = '0;
  logic [1:0]  axi_rresp = '0;
  logic        axi_rready;
  logic        br_misp_m = 1'b0;
  logic [31:1] pc_m = '0;
  logic        valid_d0;
  logic [31:0] instr_d0;
  logic [31:1] pc_d0;
  logic        comp_d0;
  logic        br_d0;
  logic        br_ataken_d0;
  logic        illegal_d0;

  line_u       prog [512];
  logic [31:0] meta_instr [2048];     // expected instr_d0 per halfword start
  logic        meta_comp [2048];
  logic        meta_ill [2048];
  logic        meta_br [2048];
  logic        meta_jump [2048];
  int          meta_off [2048];       // byte offset of the branch target
  logic        fault_line [512];
  int          kind [1024];

  logic        stall_on = 1'b0;
  logic        misp_on = 1'b0;
  int          matched = 0;
  int          errors = 0;
  int          cycles = 0;
  int          mem_cycle = 0;
  logic [31:0] model_pc = '0;
  logic [31:0] q_addr [$];
  logic [1:0]  q_id [$];
  int          q_due [$];

  fetch_top #(
    .axi_id_width(2),
    .reset_pc    (32'h0)
  ) i_dut (
    .clk(clk), .rst_n(rst_n),
    .axi_arvalid(axi_arvalid), .axi_arready(axi_arready), .axi_araddr(axi_araddr),
    .axi_arid(axi_arid), .axi_rvalid(axi_rvalid), .axi_rdata(axi_rdata),
    .axi_rid(axi_rid), .axi_rresp(axi_rresp), .axi_rready(axi_rready),
    .br_misp_m(br_misp_m), .pc_m(pc_m),
    .valid_d0(valid_d0), .instr_d0(instr_d0), .pc_d0(pc_d0), .comp_d0(comp_d0),
    .br_d0(br_d0), .br_ataken_d0(br_ataken_d0), .illegal_d0(illegal_d0)
  );

  initial forever #50 clk = ~clk;

  // ##########################################################
  // program generation
  // ##########################################################

  function automatic logic [31:0] enc_jal(input int off);
    logic [31:0] o;
    o = off;
    return {o[20], o[10:1], o[11], o[19:12], 5'd1, op_jal};
  endfunction

  function automatic logic [31:0] enc_b(input int off, input logic [31:0] r);
    logic [31:0] o;
    o = off;
    return {o[12], o[10:5], r[24:20], r[19:15], 2'b00, r[0], o[4:1], o[11], op_branch};
  endfunction

  function automatic parcel_t enc_cj(input int off);
    logic [31:0] o;
    o = off;
    return {c_funct_j, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
  endfunction

  function automatic parcel_t enc_cb(input int off, input logic [31:0] r);
    logic [31:0] o;
    o = off;
    return {(r[1] ? c_funct_bnez : c_funct_beqz), o[8], o[4:3], r[4:2], o[7:6], o[2:1],
            o[5], 2'b01};
  endfunction

  function automatic parcel_t c_fill();
    logic [31:0] r;
    r = $urandom;
    if (r[17]) return {r[15:2], 2'b10};  // quadrant 0 or 2 only so never a jump
    if (r[15:2] == 14'd0) return 16'h0004;
    return {r[15:2], 2'b00};
  endfunction

  // halfword index of a random instruction start in words lo..hi
  function automatic int pick_target(input int lo, input int hi);
    int tw;
    logic [31:0] r;
    if (lo < 0) lo = 0;
    if (hi > 1023) hi = 1023;
    r  = $urandom;
    tw = lo + int'(r[30:0] % (hi - lo + 1));
    if ((kind[tw] == 1 || kind[tw] == 4 || kind[tw] == 5 || kind[tw] == 7) && r[31])
      return 2 * tw + 1;
    return 2 * tw;
  endfunction

  task automatic set_parcel(input int h, input parcel_t p, input logic br, input logic jump,
                            input int off);
    prog[h / 4].parcels[h % 4] = p;
    meta_instr[h] = {16'h0000, p};
    meta_comp[h]  = 1'b1;
    meta_ill[h]   = (p == 16'h0000);
    meta_br[h]    = br;
    meta_jump[h]  = jump;
    meta_off[h]   = off;
  endtask

  task automatic set_word(input int w, input logic [31:0] instr, input logic br,
                          input logic jump, input int off);
    prog[w / 2].words[w % 2] = instr;
    meta_instr[2 * w] = instr;
    meta_comp[2 * w]  = 1'b0;
    meta_ill[2 * w]   = (instr == 32'hffff_ffff);
    meta_br[2 * w]    = br;
    meta_jump[2 * w]  = jump;
    meta_off[2 * w]   = off;
  endtask

  task automatic build_program();
    int r;
    int s;
    int t;
    logic [31:0] rw;
    for (int w = 0; w < 1024; w++) begin
      r = int'($urandom % 100);
      kind[w] = r < 7 ? 2 : r < 14 ? 3 : r < 21 ? 4 : r < 28 ? 5 : r < 30 ? 6 :
                r < 32 ? 7 : r < 62 ? 1 : 0;
    end
    for (int w = 0; w < 1024; w++) begin
      rw = $urandom;
      s  = 2 * w + int'(rw[0]);  // slot of a compressed jump inside its word
      case (kind[w])
        0: set_word(w, {rw[31:7], 7'b0010011}, 1'b0, 1'b0, 0);
        1, 7: begin
          set_parcel(2 * w, kind[w] == 7 ? 16'h0000 : c_fill(), 1'b0, 1'b0, 0);
          set_parcel(2 * w + 1, kind[w] == 7 ? 16'h0000 : c_fill(), 1'b0, 1'b0, 0);
        end
        2: begin
          t = pick_target(0, 1023);
          set_word(w, enc_jal((t - 2 * w) * 2), 1'b1, 1'b1, (t - 2 * w) * 2);
        end
        3: begin
          t = pick_target(w - 1000, w + 1000);
          set_word(w, enc_b((t - 2 * w) * 2, rw), 1'b1, 1'b0, (t - 2 * w) * 2);
        end
        4, 5: begin
          t = kind[w] == 4 ? pick_target(w - 500, w + 500) : pick_target(w - 60, w + 60);
          set_parcel(s, kind[w] == 4 ? enc_cj((t - s) * 2) : enc_cb((t - s) * 2, rw),
                     1'b1, kind[w] == 4, (t - s) * 2);
          set_parcel(4 * w + 1 - s, c_fill(), 1'b0, 1'b0, 0);
        end
        default: set_word(w, 32'hffff_ffff, 1'b0, 1'b0, 0);
      endcase
    end
    for (int i = 0; i < 512; i++) fault_line[i] = ($urandom % 32 == 0);
  endtask

  // ##########################################################
  // AXI memory model with single beats in order
  // ##########################################################

  always @(posedge clk) begin : mem_model
    logic [31:0] a;
    logic [31:0] r;
    if (!rst_n) begin
      q_addr.delete();
      q_id.delete();
      q_due.delete();
      axi_rvalid  <= 1'b0;
      axi_arready <= 1'b0;
    end else begin
      mem_cycle++;
      r = $urandom;
      if (axi_arvalid && axi_arready) begin
        q_addr.push_back(axi_araddr);
        q_id.push_back(axi_arid);
        q_due.push_back(mem_cycle + 1 + (stall_on ? int'(r[6:4]) : 0));
      end
      if (axi_rvalid) begin
        void'(q_addr.pop_front());
        void'(q_id.pop_front());
        void'(q_due.pop_front());
      end
      if (q_addr.size() > 0 && q_due[0] <= mem_cycle && !(stall_on && r[9:8] == 2'b00)) begin
        a = q_addr[0];
        axi_rvalid <= 1'b1;
        axi_rdata  <= prog[a[11:3]];
        axi_rid    <= q_id[0];
        axi_rresp  <= fault_line[a[11:3]] ? 2'b10 : 2'b00;
      end else begin
        axi_rvalid <= 1'b0;
      end
      axi_arready <= stall_on ? (r[1:0] != 2'b00) : 1'b1;
    end
  end

  // ##########################################################
  // checks and reference model
  // ##########################################################

  task automatic check_instr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t instr_d0 got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_pc(input logic [31:1] got, input logic [31:1] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t pc_d0 got %h expected %h", $time, {got, 1'b0}, {exp, 1'b0});
    end
  endtask

  task automatic check_flags(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t comp/br/taken/illegal got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_rready(input logic got);
    if (got !== 1'b1) begin
      errors++;
      $display("Fail t=%0t axi_rready got %b expected 1", $time, got);
    end
  endtask

  always @(posedge clk) begin : model_check
    logic [10:0] h;
    logic        exp_taken;
    logic        exp_ill;
    logic [31:0] r;
    if (!rst_n) begin
      model_pc = 32'h0;
      br_misp_m <= 1'b0;
    end else begin
      check_rready(axi_rready);
      if (valid_d0) begin
        h         = model_pc[11:1];
        exp_taken = meta_br[h] && (meta_jump[h] || meta_off[h] < 0);
        exp_ill   = meta_ill[h] || fault_line[model_pc[11:3]];
        check_instr(instr_d0, meta_instr[h]);
        check_pc(pc_d0, model_pc[31:1]);
        check_flags({comp_d0, br_d0, br_ataken_d0, illegal_d0},
                    {meta_comp[h], meta_br[h], exp_taken, exp_ill});
        matched++;
        if (exp_taken) model_pc = model_pc + meta_off[h];
        else model_pc = model_pc + (meta_comp[h] ? 32'd2 : 32'd4);
      end else begin
        check_instr(instr_d0, nop_instr);
      end
      if (br_misp_m) model_pc = {pc_m, 1'b0};  // the pick of this cycle is dropped
      r = $urandom;
      if (misp_on && matched < n_per_test && r[4:0] == 5'd0) begin
        br_misp_m <= 1'b1;
        pc_m      <= 31'(pick_target(0, 1023));
      end else begin
        br_misp_m <= 1'b0;
      end
    end
  end

  task automatic run_test(input string name, input logic stalls, input logic misps);
    int err_before;
    err_before = errors;
    @(posedge clk);
    rst_n    <= 1'b0;
    stall_on <= stalls;
    misp_on  <= misps;
    repeat (10) @(posedge clk);
    matched = 0;
    rst_n <= 1'b1;
    while (matched < n_per_test) @(negedge clk);
    $display("test %s: %0d instructions, %0d errors", name, matched, errors - err_before);
  endtask

  initial begin
    void'($urandom(66863));
    build_program();
    run_test("sequential and branches", 1'b0, 1'b0);
    run_test("axi stalls", 1'b1, 1'b0);
    run_test("mispredicts", 1'b0, 1'b1);
    run_test("stalls and mispredicts", 1'b1, 1'b1);
    $display("tests %0d, instructions %0d, errors %0d", n_tests, n_tests * n_per_test, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
source/fetch_pkg.sv
source/fetch_mem_ctrl.sv
source/parcel_predecode.sv
source/fetch_sequencer.sv
source/fetch_top.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module fetch_tb -Mdir obj_dir \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vfetch_tb > sim.log 2>&1
cat sim.log
grep -q '^=== PASS ===$' sim.log && exit 0 || exit 1
